/* Makefile */
# Verilator lint and simulation of the 4x4 texture distortion unit

VERILATOR ?= verilator
TOP       ?= disto4x4_tb
RTL_TOP   ?= disto4x4_top
FILELIST  ?= disto4x4_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100000
PASS_TEXT ?= All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(TOP): $(FILELIST) $(wildcard logic/*.sv logic/*.svh sim/*.sv)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)

sim: $(BUILD_DIR)/$(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* disto4x4_top.f */
+incdir+logic
logic/disto_pkg.sv
logic/hadamard_pass.sv
logic/weighted_abs_sum.sv
logic/disto_combine.sv
logic/disto4x4_top.sv
sim/disto4x4_properties.sv
sim/disto4x4_tb.sv

/* logic/disto4x4_top.sv */
// Four-stage pipelined 4x4 texture distortion: two Hadamard passes, weighted sums, difference

`include "disto_settings.svh"

module disto4x4_top (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               start,
    input  disto_pkg::disto_job_t              job,
    output logic signed [`DISTO_SUM_BITS-1:0]  distortion,
    output logic                               done
);

    // Stage 1 outputs, rows transformed and transposed
    logic                    s1_valid_a;
    logic                    s1_valid_b;
    logic                    s1_valid;
    disto_pkg::row_block_t   s1_block_a;
    disto_pkg::row_block_t   s1_block_b;

    // Stage 2 outputs, full 2-D transform in original orientation
    logic                    s2_valid_a;
    logic                    s2_valid_b;
    logic                    s2_valid;
    disto_pkg::coef_block_t  s2_coef_a;
    disto_pkg::coef_block_t  s2_coef_b;

    // Stage 3 outputs
    logic                    s3_valid;
    disto_pkg::sum_pair_t    s3_sums;

    // Weights travel two cycles to meet stage 3
    disto_pkg::weight_block_t weights_d1;
    disto_pkg::weight_block_t weights_d2;

    // Both lanes advance in lockstep
    assign s1_valid = s1_valid_a & s1_valid_b;
    assign s2_valid = s2_valid_a & s2_valid_b;

    // ------------------------------------------------------------------------
    // Weight delay line
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (start) begin
            weights_d1 <= job.weights;
        end
        if (s1_valid) begin
            weights_d2 <= weights_d1;
        end
    end

    // ------------------------------------------------------------------------
    // Stage 1 row pass
    // ------------------------------------------------------------------------
    hadamard_pass #(
        .in_t  (disto_pkg::pixel_t),
        .out_t (disto_pkg::row_coef_t)
    ) u_row_a (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (start),
        .in_block  (job.block_a),
        .out_valid (s1_valid_a),
        .out_block (s1_block_a)
    );

    hadamard_pass #(
        .in_t  (disto_pkg::pixel_t),
        .out_t (disto_pkg::row_coef_t)
    ) u_row_b (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (start),
        .in_block  (job.block_b),
        .out_valid (s1_valid_b),
        .out_block (s1_block_b)
    );

    // ------------------------------------------------------------------------
    // Stage 2 column pass on the transposed rows
    // ------------------------------------------------------------------------
    hadamard_pass #(
        .in_t  (disto_pkg::row_coef_t),
        .out_t (disto_pkg::coef_t)
    ) u_col_a (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (s1_valid),
        .in_block  (s1_block_a),
        .out_valid (s2_valid_a),
        .out_block (s2_coef_a)
    );

    hadamard_pass #(
        .in_t  (disto_pkg::row_coef_t),
        .out_t (disto_pkg::coef_t)
    ) u_col_b (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (s1_valid),
        .in_block  (s1_block_b),
        .out_valid (s2_valid_b),
        .out_block (s2_coef_b)
    );

    // Stage 3 weighted sums
    weighted_abs_sum u_sum (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (s2_valid),
        .coef_a    (s2_coef_a),
        .coef_b    (s2_coef_b),
        .weights   (weights_d2),
        .out_valid (s3_valid),
        .sums      (s3_sums)
    );

    // Stage 4 difference and done
    disto_combine u_combine (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (s3_valid),
        .sums       (s3_sums),
        .distortion (distortion),
        .done       (done)
    );

endmodule

/* logic/disto_combine.sv */
// Final stage: magnitude of the sum difference, scaled down, registered with done

`include "disto_settings.svh"

module disto_combine (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               in_valid,
    input  disto_pkg::sum_pair_t               sums,
    output logic signed [`DISTO_SUM_BITS-1:0]  distortion,
    output logic                               done
);

    // Signed difference B minus A
    logic signed [`DISTO_SUM_BITS-1:0] diff;
    // Its magnitude
    logic        [`DISTO_SUM_BITS-1:0] mag;

    assign diff = sums.sum_b - sums.sum_a;

    always_comb begin
        if (diff < 0) begin
            mag = -diff;
        end else begin
            mag = diff;
        end
    end

    // ------------------------------------------------------------------------
    // Output registers
    // ------------------------------------------------------------------------
    // One-cycle done per valid job
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= in_valid;
        end
    end

    // Logical shift on the magnitude, result never negative
    always_ff @(posedge clk) begin
        if (in_valid) begin
            distortion <= signed'(mag >> `DISTO_SHIFT);
        end
    end

endmodule

/* logic/disto_pkg.sv */
// Shared data types of the distortion pipeline: samples, coefficients, blocks and stage payloads

`include "disto_settings.svh"

package disto_pkg;

    // -----------------------------------------------------------------------
    // Element types
    // -----------------------------------------------------------------------
    // Raw unsigned sample
    typedef logic [`DISTO_PIXEL_BITS-1:0] pixel_t;

    // Row pass result, sum of four samples needs 2 more bits plus sign
    typedef logic signed [`DISTO_PIXEL_BITS+2:0] row_coef_t;

    // Column pass result, two more bits again
    typedef logic signed [`DISTO_PIXEL_BITS+4:0] coef_t;

    // Per-position weight
    typedef logic [`DISTO_WEIGHT_BITS-1:0] weight_t;

    // -----------------------------------------------------------------------
    // Block types, row-major with index row*4+col
    // -----------------------------------------------------------------------
    typedef pixel_t    [`DISTO_BLOCK_ELEMS-1:0] pixel_block_t;
    typedef row_coef_t [`DISTO_BLOCK_ELEMS-1:0] row_block_t;
    typedef coef_t     [`DISTO_BLOCK_ELEMS-1:0] coef_block_t;
    typedef weight_t   [`DISTO_BLOCK_ELEMS-1:0] weight_block_t;

    // -----------------------------------------------------------------------
    // Stage payloads
    // -----------------------------------------------------------------------
    // One job as presented with start
    typedef struct packed {
        pixel_block_t  block_a;
        pixel_block_t  block_b;
        weight_block_t weights;
    } disto_job_t;

    // Weighted sums of both blocks
    typedef struct packed {
        logic signed [`DISTO_SUM_BITS-1:0] sum_a;
        logic signed [`DISTO_SUM_BITS-1:0] sum_b;
    } sum_pair_t;

endpackage

/* logic/disto_settings.svh */
// Constants for the 4x4 texture distortion unit: block size, widths and output shift

`ifndef DISTO_SETTINGS_SVH
`define DISTO_SETTINGS_SVH

// ---------------------------------------------------------------------------
// Block geometry
// ---------------------------------------------------------------------------
// Edge of the square block
`define DISTO_BLOCK_SIZE  4
// Samples per block in row-major order
`define DISTO_BLOCK_ELEMS (`DISTO_BLOCK_SIZE * `DISTO_BLOCK_SIZE)

// ---------------------------------------------------------------------------
// Data widths
// ---------------------------------------------------------------------------
`define DISTO_PIXEL_BITS  8
`define DISTO_WEIGHT_BITS 16
// Weighted sums and result
`define DISTO_SUM_BITS    32

// Final right shift of the magnitude
`define DISTO_SHIFT       5
// Cycles from start to done, one per pipeline stage
`define DISTO_LATENCY     4

`endif

/* logic/hadamard_pass.sv */
// One registered 4-point Hadamard pass over every row of a block, stored transposed

`include "disto_settings.svh"

module hadamard_pass #(
    parameter type in_t  = disto_pkg::pixel_t,
    parameter type out_t = disto_pkg::row_coef_t
) (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              in_valid,
    input  in_t  [`DISTO_BLOCK_ELEMS-1:0]     in_block,
    output logic                              out_valid,
    output out_t [`DISTO_BLOCK_ELEMS-1:0]     out_block
);

    localparam int N = `DISTO_BLOCK_SIZE;

    // Butterfly results already placed at transposed positions
    out_t [`DISTO_BLOCK_ELEMS-1:0] transposed;

    // ------------------------------------------------------------------------
    // Row butterflies
    // ------------------------------------------------------------------------
    for (genvar r = 0; r < N; r++) begin : g_row
        // Row samples widened to the output type
        out_t x0;
        out_t x1;
        out_t x2;
        out_t x3;
        // First butterfly level
        out_t a0;
        out_t a1;
        out_t a2;
        out_t a3;

        // Inner cast keeps the sign of signed inputs before extension
        assign x0 = out_t'(in_t'(in_block[r*N+0]));
        assign x1 = out_t'(in_t'(in_block[r*N+1]));
        assign x2 = out_t'(in_t'(in_block[r*N+2]));
        assign x3 = out_t'(in_t'(in_block[r*N+3]));

        // Pairs (0,2) and (1,3)
        assign a0 = x0 + x2;
        assign a1 = x1 + x3;
        assign a2 = x1 - x3;
        assign a3 = x0 - x2;

        // Second level, written to column r of the output
        assign transposed[0*N+r] = a0 + a1;
        assign transposed[1*N+r] = a3 + a2;
        assign transposed[2*N+r] = a3 - a2;
        assign transposed[3*N+r] = a0 - a1;
    end

    // ------------------------------------------------------------------------
    // Output registers
    // ------------------------------------------------------------------------
    // Valid follows the input one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Block only loads on a valid job, holds otherwise
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_block <= transposed;
        end
    end

endmodule

/* logic/weighted_abs_sum.sv */
// Registered weighted sum of absolute Hadamard coefficients for both blocks of a job

`include "disto_settings.svh"

module weighted_abs_sum (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  disto_pkg::coef_block_t    coef_a,
    input  disto_pkg::coef_block_t    coef_b,
    input  disto_pkg::weight_block_t  weights,
    output logic                      out_valid,
    output disto_pkg::sum_pair_t      sums
);

    localparam int SUM_W = `DISTO_SUM_BITS;

    typedef logic [SUM_W-1:0] acc_t;

    // Sixteen |coef| * weight products added up
    function automatic acc_t block_sum(
        input disto_pkg::coef_block_t   coef,
        input disto_pkg::weight_block_t w
    );
        acc_t                                  acc;
        disto_pkg::coef_t                      c;
        logic [$bits(disto_pkg::coef_t)-1:0]   mag;

        acc = '0;
        for (int i = 0; i < `DISTO_BLOCK_ELEMS; i++) begin
            c = coef[i];
            // Magnitude fits, range is +-4080
            if (c < 0) begin
                mag = -c;
            end else begin
                mag = c;
            end
            acc = acc + acc_t'(mag) * acc_t'(w[i]);
        end
        return acc;
    endfunction

    acc_t sum_a_next;
    acc_t sum_b_next;

    // Same weights for both blocks
    assign sum_a_next = block_sum(coef_a, weights);
    assign sum_b_next = block_sum(coef_b, weights);

    // ------------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Sums are payload, held between jobs
    always_ff @(posedge clk) begin
        if (in_valid) begin
            sums.sum_a <= signed'(sum_a_next);
            sums.sum_b <= signed'(sum_b_next);
        end
    end

endmodule

/* sim/disto4x4_properties.sv */
// Bound checker for the distortion pipeline: reference model, reset, latency and value assertions

`include "disto_settings.svh"

module disto4x4_properties (
    input logic                               clk,
    input logic                               reset,
    input logic                               start,
    input disto_pkg::disto_job_t              job,
    input logic signed [`DISTO_SUM_BITS-1:0]  distortion,
    input logic                               done
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int LAT = `DISTO_LATENCY;
    localparam int N   = `DISTO_BLOCK_SIZE;
    // Basis signs, bit row*4+tap set means minus: ++++ ++-- +--+ +-+-
    localparam logic [15:0] MINUS = 16'b1010_0110_1100_0000;

    // Failed assertions so far, read by the testbench
    int fail_count = 0;

    // Outputs are defined once reset has been seen
    logic armed = 1'b0;
    // Cycles since reset release, saturates past the latency
    int settle_cnt = 0;
    // One slot per cycle of flight, oldest slot meets done
    logic [LAT-1:0] start_hist = '0;
    logic [LAT-1:0] same_hist = '0;
    longint expect_hist [0:LAT-1];

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    // C = H X H^T, then sum of |C| times weight
    function automatic longint weighted_energy(input disto_pkg::pixel_block_t blk,
                                               input disto_pkg::weight_block_t w);
        longint acc;
        longint coef;
        longint pix;
        acc = 0;
        for (int u = 0; u < N; u++) begin
            for (int v = 0; v < N; v++) begin
                coef = 0;
                for (int r = 0; r < N; r++) begin
                    for (int c = 0; c < N; c++) begin
                        pix = longint'(blk[r*N+c]);
                        coef += (MINUS[u*N+r] ^ MINUS[v*N+c]) ? -pix : pix;
                    end
                end
                acc += (coef < 0 ? -coef : coef) * longint'(w[u*N+v]);
            end
        end
        return acc;
    endfunction

    // |B - A| scaled down
    function automatic longint reference_distortion(input disto_pkg::disto_job_t j);
        longint diff;
        diff = weighted_energy(j.block_b, j.weights) - weighted_energy(j.block_a, j.weights);
        if (diff < 0) begin
            diff = -diff;
        end
        return diff >> `DISTO_SHIFT;
    endfunction

    // ------------------------------------------------------------------------
    // History of started jobs
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        if (reset) begin
            armed      <= 1'b1;
            settle_cnt <= 0;
            start_hist <= '0;
        end else begin
            if (settle_cnt <= LAT) begin
                settle_cnt <= settle_cnt + 1;
            end
            start_hist <= {start_hist[LAT-2:0], start};
        end
        same_hist      <= {same_hist[LAT-2:0], job.block_a == job.block_b};
        expect_hist[0] <= reference_distortion(job);
        for (int i = 1; i < LAT; i++) begin
            expect_hist[i] <= expect_hist[i-1];
        end
    end

    // ------------------------------------------------------------------------
    // Assertions
    // ------------------------------------------------------------------------
    quiet_after_reset: assert property (@(posedge clk) armed && settle_cnt < LAT |-> !done)
        else begin
            fail_count++;
            $error("** Error at %0t: done expected 0, got 1, %0d cycles after reset", $time,
                   $sampled(settle_cnt));
        end

    // Exactly one done per start, fixed distance
    done_follows_start: assert property (@(posedge clk) armed |-> done == start_hist[LAT-1])
        else begin
            fail_count++;
            $error("** Error at %0t: done expected %0b, got %0b", $time,
                   $sampled(start_hist[LAT-1]), $sampled(done));
        end

    result_matches_model: assert property (@(posedge clk)
        done |-> longint'(distortion) == expect_hist[LAT-1])
        else begin
            fail_count++;
            $error("** Error at %0t: distortion expected %0d, got %0d", $time,
                   $sampled(expect_hist[LAT-1]), $sampled(distortion));
        end

    // Same texture on both sides
    identical_is_zero: assert property (@(posedge clk)
        done && same_hist[LAT-1] |-> distortion == 0)
        else begin
            fail_count++;
            $error("** Error at %0t: distortion expected 0, got %0d", $time,
                   $sampled(distortion));
        end

endmodule

bind disto4x4_top disto4x4_properties props (.*);

/* sim/disto4x4_tb.sv */
// Testbench for the 4x4 distortion pipeline: LFSR and corner-case jobs, checked by bound assertions

`include "disto_settings.svh"

module disto4x4_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N            = `DISTO_BLOCK_SIZE;
    localparam int LAT          = `DISTO_LATENCY;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_CYCLES  = 6;
    localparam int SINGLE_JOBS  = 8;
    localparam int SAME_JOBS    = 4;
    localparam int SWAP_PAIRS   = 4;
    localparam int EXTREME_JOBS = 4;
    localparam int STREAM_JOBS  = 32;
    // Lone job: start, release, latency, done count and report settle
    localparam int JOB_COST     = LAT + 5;
    localparam int MAX_CYCLES   = RESET_CYCLES + IDLE_CYCLES
        + (SINGLE_JOBS + SAME_JOBS + 2 * SWAP_PAIRS + EXTREME_JOBS) * JOB_COST
        + STREAM_JOBS + 6 * JOB_COST + 50;

    logic                               clk = 1'b0;
    logic                               reset;
    logic                               start;
    disto_pkg::disto_job_t              job;
    logic signed [`DISTO_SUM_BITS-1:0]  distortion;
    logic                               done;

    logic [15:0] lfsr_state = 16'd43145;
    int cycle_count = 0;
    int done_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    disto_pkg::disto_job_t job_queue[$];

    disto4x4_top uut (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .job        (job),
        .distortion (distortion),
        .done       (done)
    );

    always #4 clk = ~clk;

    // Done counter and run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (!reset && done) begin
            done_count <= done_count + 1;
        end
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: no finish within %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------------
    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[14:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    task automatic random_job(output disto_pkg::disto_job_t jv);
        logic [15:0] bits;
        for (int i = 0; i < N * N; i++) begin
            take_bits(`DISTO_PIXEL_BITS, bits);
            jv.block_a[i] = bits[7:0];
            take_bits(`DISTO_PIXEL_BITS, bits);
            jv.block_b[i] = bits[7:0];
            take_bits(`DISTO_WEIGHT_BITS, bits);
            jv.weights[i] = bits;
        end
    endtask

    function automatic disto_pkg::disto_job_t swap_blocks(input disto_pkg::disto_job_t j);
        disto_pkg::disto_job_t s;
        s = j;
        s.block_a = j.block_b;
        s.block_b = j.block_a;
        return s;
    endfunction

    // Full white against checkerboard or black, weights at maximum
    function automatic disto_pkg::disto_job_t extreme_job(input bit use_checkerboard);
        disto_pkg::disto_job_t jv;
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                jv.block_a[r*N+c] = 8'hFF;
                jv.block_b[r*N+c] = (use_checkerboard && (r + c) % 2 == 1) ? 8'hFF : 8'h00;
                jv.weights[r*N+c] = 16'hFFFF;
            end
        end
        return jv;
    endfunction

    task automatic wait_done(input int target);
        while (done_count < target) begin
            @(posedge clk);
        end
    endtask

    // Sends the queued jobs, alone or back to back, then reports
    task automatic run_test(input string name, input bit streamed, input int idle);
        int failures_before;
        int issued;
        failures_before = uut.props.fail_count;
        issued = done_count;
        repeat (idle) @(posedge clk);
        foreach (job_queue[i]) begin
            @(posedge clk);
            start <= 1'b1;
            job   <= job_queue[i];
            issued++;
            if (!streamed) begin
                @(posedge clk);
                start <= 1'b0;
                wait_done(issued);
            end
        end
        @(posedge clk);
        start <= 1'b0;
        wait_done(issued);
        // Room for the checks on the last done
        repeat (2) @(posedge clk);
        tests_run++;
        if (uut.props.fail_count != failures_before) begin
            tests_failed++;
        end
        $display("Test %s: %0d jobs, %0d assertion failures", name, job_queue.size(),
                 uut.props.fail_count - failures_before);
        job_queue.delete();
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        disto_pkg::disto_job_t jv;
        reset = 1'b1;
        start = 1'b0;
        job = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        run_test("reset_quiet", 1'b0, IDLE_CYCLES);

        for (int n = 0; n < SINGLE_JOBS; n++) begin
            random_job(jv);
            job_queue.push_back(jv);
        end
        run_test("single_random", 1'b0, 0);

        for (int n = 0; n < SAME_JOBS; n++) begin
            random_job(jv);
            jv.block_b = jv.block_a;
            job_queue.push_back(jv);
        end
        run_test("identical_blocks", 1'b0, 0);

        // Each job followed by its mirror
        for (int n = 0; n < SWAP_PAIRS; n++) begin
            random_job(jv);
            job_queue.push_back(jv);
            job_queue.push_back(swap_blocks(jv));
        end
        run_test("swapped_blocks", 1'b0, 0);

        job_queue.push_back(extreme_job(1'b1));
        job_queue.push_back(swap_blocks(extreme_job(1'b1)));
        job_queue.push_back(extreme_job(1'b0));
        job_queue.push_back(swap_blocks(extreme_job(1'b0)));
        run_test("extreme_input", 1'b0, 0);

        for (int n = 0; n < STREAM_JOBS; n++) begin
            random_job(jv);
            job_queue.push_back(jv);
        end
        run_test("full_pipeline", 1'b1, 0);

        $display("Summary: %0d tests, %0d failed, %0d assertion failures, %0d done pulses",
                 tests_run, tests_failed, uut.props.fail_count, done_count);
        if (tests_failed == 0 && uut.props.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
